/* issue_pkg.sv */
/* Shared types and constants for the issue stage of the scalar/matrix core.
   Every module refers to these by scoped name. */
`default_nettype none

package issue_pkg;

    // Table geometry and datapath widths
    localparam int NUM_ROWS = 5;
    localparam int NUM_REGS = 32;
    localparam int REG_W    = 5;
    localparam int WORD_W   = 32;
    localparam int MREG_W   = 4;
    localparam int AGE_W    = 3;

    // Row index of each functional unit
    localparam int ROW_ALU    = 0;
    localparam int ROW_LD_ST  = 1;
    localparam int ROW_BRANCH = 2;
    localparam int ROW_MLS    = 3;
    localparam int ROW_GEMM   = 4;

    // Encoding is row index plus one, zero means no producer to wait on
    typedef enum logic [2:0] {
        FU_NONE   = 3'd0,
        FU_ALU    = 3'd1,
        FU_LD_ST  = 3'd2,
        FU_BRANCH = 3'd3,
        FU_MLS    = 3'd4,
        FU_GEMM   = 3'd5
    } fu_e;

    typedef enum logic [1:0] {
        FUST_EMPTY,
        FUST_WAIT,
        FUST_RDY,
        FUST_EX
    } fust_state_e;

    typedef struct packed {
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        fu_e              t1;
        fu_e              t2;
    } fust_s_row_t;

    typedef struct packed {
        logic [MREG_W-1:0] ms1;
        logic [MREG_W-1:0] ms2;
        logic [MREG_W-1:0] ms3;
        fu_e               t1;
        fu_e               t2;
        fu_e               t3;
    } fust_m_row_t;

    typedef struct packed {
        logic        s_en;
        fu_e         s_fu;
        fust_s_row_t s_row;
        logic        m_en;
        fust_m_row_t m_row;
        logic        g_en;
        fust_m_row_t g_row;
    } dispatch_t;

    typedef struct packed {
        logic              rw_en;
        logic [REG_W-1:0]  rw;
        logic [WORD_W-1:0] wdata;
        fu_e               done_fu;
    } wb_t;

    typedef struct packed {
        logic              valid;
        fu_e               fu;
        logic [WORD_W-1:0] rdat1;
        logic [WORD_W-1:0] rdat2;
        logic [MREG_W-1:0] ms1;
        logic [MREG_W-1:0] ms2;
        logic [MREG_W-1:0] ms3;
    } issue_t;

    // One bit per table row
    typedef logic [NUM_ROWS-1:0] row_status_t;

    // A tag naming the unit that just completed no longer blocks
    function automatic fu_e clear_tag(fu_e tag, fu_e done);
        return (done != FU_NONE && tag == done) ? FU_NONE : tag;
    endfunction

endpackage

`default_nettype wire

/* regfile.sv */
/* Scalar register file, 32 x 32 bits, written by the writeback bus.
   Two combinational read ports see a same-cycle write. */
`default_nettype none

module regfile (
    input  logic                          CLK,
    input  logic                          nRST,
    input  issue_pkg::wb_t                wb,
    input  logic [issue_pkg::REG_W-1:0]   rsel1,
    input  logic [issue_pkg::REG_W-1:0]   rsel2,
    output logic [issue_pkg::WORD_W-1:0]  rdat1,
    output logic [issue_pkg::WORD_W-1:0]  rdat2
);
    logic [issue_pkg::WORD_W-1:0] regs [issue_pkg::NUM_REGS];

    // x0 is never written
    always_ff @(posedge CLK) begin
        if (wb.rw_en && wb.rw != '0) begin
            regs[wb.rw] <= wb.wdata;
        end
    end

    always_comb begin
        rdat1 = (wb.rw_en && wb.rw == rsel1) ? wb.wdata : regs[rsel1];
        rdat2 = (wb.rw_en && wb.rw == rsel2) ? wb.wdata : regs[rsel2];
        if (rsel1 == '0) rdat1 = '0;
        if (rsel2 == '0) rdat2 = '0;
    end

    a_wb_sel_known: assert property (@(posedge CLK) disable iff (!nRST)
        wb.rw_en |-> !$isunknown(wb.rw));

endmodule

`default_nettype wire

/* fust_scalar.sv */
/* Status table rows for the ALU, LD_ST and BRANCH units.
   Dispatch fills a row, writeback clears tags that name the finished unit. */
`default_nettype none

module fust_scalar (
    input  logic                            CLK,
    input  logic                            nRST,
    input  issue_pkg::dispatch_t            dispatch,
    input  issue_pkg::wb_t                  wb,
    output issue_pkg::fust_s_row_t [2:0]    rows,
    output logic [2:0]                      tags_clear
);
    logic [2:0]                   wr_sel;
    issue_pkg::fust_s_row_t [2:0] rows_next;

    // Row picked by the dispatched unit
    always_comb begin
        wr_sel = '0;
        if (dispatch.s_en) begin
            case (dispatch.s_fu)
                issue_pkg::FU_ALU:    wr_sel[issue_pkg::ROW_ALU]    = 1'b1;
                issue_pkg::FU_LD_ST:  wr_sel[issue_pkg::ROW_LD_ST]  = 1'b1;
                issue_pkg::FU_BRANCH: wr_sel[issue_pkg::ROW_BRANCH] = 1'b1;
                default:              wr_sel = '0;
            endcase
        end
    end

    // A fresh row also drops a tag on the unit finishing this cycle
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            rows_next[i]    = wr_sel[i] ? dispatch.s_row : rows[i];
            rows_next[i].t1 = issue_pkg::clear_tag(rows_next[i].t1, wb.done_fu);
            rows_next[i].t2 = issue_pkg::clear_tag(rows_next[i].t2, wb.done_fu);
            tags_clear[i]   = rows[i].t1 == issue_pkg::FU_NONE &&
                              rows[i].t2 == issue_pkg::FU_NONE;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rows <= '0;
        end else begin
            rows <= rows_next;
        end
    end

    a_scalar_fu: assert property (@(posedge CLK) disable iff (!nRST)
        dispatch.s_en |-> dispatch.s_fu inside
            {issue_pkg::FU_ALU, issue_pkg::FU_LD_ST, issue_pkg::FU_BRANCH});

endmodule

`default_nettype wire

/* fust_matrix.sv */
/* Status table rows for the matrix load/store and GEMM units.
   MLS waits on two producers, GEMM on three. */
`default_nettype none

module fust_matrix (
    input  logic                      CLK,
    input  logic                      nRST,
    input  issue_pkg::dispatch_t      dispatch,
    input  issue_pkg::wb_t            wb,
    output issue_pkg::fust_m_row_t    mls_row,
    output issue_pkg::fust_m_row_t    gemm_row,
    output logic [1:0]                tags_clear
);
    issue_pkg::fust_m_row_t mls_next;
    issue_pkg::fust_m_row_t gemm_next;

    always_comb begin
        mls_next     = dispatch.m_en ? dispatch.m_row : mls_row;
        mls_next.t1  = issue_pkg::clear_tag(mls_next.t1, wb.done_fu);
        mls_next.t2  = issue_pkg::clear_tag(mls_next.t2, wb.done_fu);

        gemm_next    = dispatch.g_en ? dispatch.g_row : gemm_row;
        gemm_next.t1 = issue_pkg::clear_tag(gemm_next.t1, wb.done_fu);
        gemm_next.t2 = issue_pkg::clear_tag(gemm_next.t2, wb.done_fu);
        gemm_next.t3 = issue_pkg::clear_tag(gemm_next.t3, wb.done_fu);
    end

    // MLS ignores its third tag
    always_comb begin
        tags_clear[0] = mls_row.t1 == issue_pkg::FU_NONE &&
                        mls_row.t2 == issue_pkg::FU_NONE;
        tags_clear[1] = gemm_row.t1 == issue_pkg::FU_NONE &&
                        gemm_row.t2 == issue_pkg::FU_NONE &&
                        gemm_row.t3 == issue_pkg::FU_NONE;
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            mls_row  <= '0;
            gemm_row <= '0;
        end else begin
            mls_row  <= mls_next;
            gemm_row <= gemm_next;
        end
    end

    a_one_matrix_dispatch: assert property (@(posedge CLK) disable iff (!nRST)
        !(dispatch.m_en && dispatch.g_en));

endmodule

`default_nettype wire

/* issue_select.sv */
/* Row state machines, ages and oldest-first pick for the five table rows.
   Loads one issue packet per cycle unless freeze is high. */
`default_nettype none

module issue_select (
    input  logic                                CLK,
    input  logic                                nRST,
    input  issue_pkg::dispatch_t                dispatch,
    input  issue_pkg::wb_t                      wb,
    input  logic                                freeze,
    input  issue_pkg::fust_s_row_t [2:0]        s_rows,
    input  issue_pkg::fust_m_row_t              mls_row,
    input  issue_pkg::fust_m_row_t              gemm_row,
    input  issue_pkg::row_status_t              tags_clear,
    input  logic [issue_pkg::WORD_W-1:0]        rdat1,
    input  logic [issue_pkg::WORD_W-1:0]        rdat2,
    output logic [issue_pkg::REG_W-1:0]         rsel1,
    output logic [issue_pkg::REG_W-1:0]         rsel2,
    output issue_pkg::row_status_t              busy,
    output issue_pkg::issue_t                   issue
);
    issue_pkg::fust_state_e [issue_pkg::NUM_ROWS-1:0]         state;
    issue_pkg::fust_state_e [issue_pkg::NUM_ROWS-1:0]         next_state;
    logic [issue_pkg::NUM_ROWS-1:0][issue_pkg::AGE_W-1:0]     age;
    logic [issue_pkg::NUM_ROWS-1:0][issue_pkg::AGE_W-1:0]     next_age;
    logic [issue_pkg::NUM_ROWS-1:0]                           incoming;
    logic [issue_pkg::NUM_ROWS-1:0]                           ready;
    logic [issue_pkg::NUM_ROWS-1:0]                           enter_ex;
    logic                                                     found;
    logic [2:0]                                               sel;
    logic [issue_pkg::AGE_W-1:0]                              best_age;
    issue_pkg::issue_t                                        next_issue;

    // Dispatch enables mapped onto rows
    always_comb begin
        incoming = '0;
        if (dispatch.s_en) begin
            case (dispatch.s_fu)
                issue_pkg::FU_ALU:    incoming[issue_pkg::ROW_ALU]    = 1'b1;
                issue_pkg::FU_LD_ST:  incoming[issue_pkg::ROW_LD_ST]  = 1'b1;
                issue_pkg::FU_BRANCH: incoming[issue_pkg::ROW_BRANCH] = 1'b1;
                default:              incoming = '0;
            endcase
        end
        incoming[issue_pkg::ROW_MLS]  = dispatch.m_en;
        incoming[issue_pkg::ROW_GEMM] = dispatch.g_en;
    end

    // Oldest ready row wins, strict compare keeps the lower index on a tie
    always_comb begin
        found    = 1'b0;
        sel      = '0;
        best_age = '0;
        for (int i = 0; i < issue_pkg::NUM_ROWS; i++) begin
            ready[i] = (state[i] == issue_pkg::FUST_WAIT || state[i] == issue_pkg::FUST_RDY)
                       && tags_clear[i];
            if (ready[i] && (!found || age[i] > best_age)) begin
                found    = 1'b1;
                sel      = 3'(i);
                best_age = age[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < issue_pkg::NUM_ROWS; i++) begin
            next_state[i] = state[i];
            next_age[i]   = '0;
            case (state[i])
                issue_pkg::FUST_EMPTY: begin
                    if (incoming[i]) begin
                        next_state[i] = issue_pkg::FUST_WAIT;
                        next_age[i]   = 1;
                    end
                end
                issue_pkg::FUST_WAIT, issue_pkg::FUST_RDY: begin
                    if (ready[i]) begin
                        next_state[i] = (found && sel == 3'(i) && !freeze) ?
                                        issue_pkg::FUST_EX : issue_pkg::FUST_RDY;
                    end
                    if (next_state[i] != issue_pkg::FUST_EX) begin
                        next_age[i] = (&age[i]) ? age[i] : age[i] + 1'b1;
                    end
                end
                // Row frees once its own unit reports completion
                issue_pkg::FUST_EX: begin
                    if (wb.done_fu == 3'(i + 1)) next_state[i] = issue_pkg::FUST_EMPTY;
                end
                default: next_state[i] = issue_pkg::FUST_EMPTY;
            endcase
            enter_ex[i] = state[i] != issue_pkg::FUST_EX && next_state[i] == issue_pkg::FUST_EX;
            busy[i]     = state[i] != issue_pkg::FUST_EMPTY;
        end
    end

    // Only scalar rows read the register file
    always_comb begin
        rsel1 = '0;
        rsel2 = '0;
        for (int i = 0; i < 3; i++) begin
            if (found && sel == 3'(i)) begin
                rsel1 = s_rows[i].rs1;
                rsel2 = s_rows[i].rs2;
            end
        end
    end

    always_comb begin
        next_issue = '0;
        if (freeze) begin
            next_issue = issue;
        end else if (found) begin
            next_issue.valid = 1'b1;
            next_issue.fu    = issue_pkg::fu_e'(sel + 3'd1);
            next_issue.rdat1 = rdat1;
            next_issue.rdat2 = rdat2;
            if (sel == 3'(issue_pkg::ROW_MLS)) begin
                next_issue.ms1 = mls_row.ms1;
                next_issue.ms2 = mls_row.ms2;
                next_issue.ms3 = mls_row.ms3;
            end else if (sel == 3'(issue_pkg::ROW_GEMM)) begin
                next_issue.ms1 = gemm_row.ms1;
                next_issue.ms2 = gemm_row.ms2;
                next_issue.ms3 = gemm_row.ms3;
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= {issue_pkg::NUM_ROWS{issue_pkg::FUST_EMPTY}};
            age   <= '0;
            issue <= '0;
        end else begin
            state <= next_state;
            age   <= next_age;
            issue <= next_issue;
        end
    end

    a_single_issue: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(enter_ex));

    a_freeze_hold: assert property (@(posedge CLK) disable iff (!nRST)
        freeze |=> $stable(issue));

endmodule

`default_nettype wire

/* issue_stage.sv */
/* Issue stage top, joining the status tables, selector and register file.
   Dispatch and writeback come in, one issue packet per cycle goes out. */
`default_nettype none

module issue_stage (
    input  logic                        CLK,
    input  logic                        nRST,
    input  issue_pkg::dispatch_t        dispatch,
    input  issue_pkg::wb_t              wb,
    input  logic                        freeze,
    output issue_pkg::issue_t           issue,
    output issue_pkg::row_status_t      busy
);
    issue_pkg::fust_s_row_t [2:0]     s_rows;
    issue_pkg::fust_m_row_t           mls_row;
    issue_pkg::fust_m_row_t           gemm_row;
    logic [2:0]                       s_tags_clear;
    logic [1:0]                       m_tags_clear;
    logic [issue_pkg::REG_W-1:0]      rsel1;
    logic [issue_pkg::REG_W-1:0]      rsel2;
    logic [issue_pkg::WORD_W-1:0]     rdat1;
    logic [issue_pkg::WORD_W-1:0]     rdat2;

    regfile regfile_i (
        .CLK   (CLK),
        .nRST  (nRST),
        .wb    (wb),
        .rsel1 (rsel1),
        .rsel2 (rsel2),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

    fust_scalar fust_scalar_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .dispatch   (dispatch),
        .wb         (wb),
        .rows       (s_rows),
        .tags_clear (s_tags_clear)
    );

    fust_matrix fust_matrix_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .dispatch   (dispatch),
        .wb         (wb),
        .mls_row    (mls_row),
        .gemm_row   (gemm_row),
        .tags_clear (m_tags_clear)
    );

    // Matrix rows sit above the scalar rows in the status vector
    issue_select issue_select_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .dispatch   (dispatch),
        .wb         (wb),
        .freeze     (freeze),
        .s_rows     (s_rows),
        .mls_row    (mls_row),
        .gemm_row   (gemm_row),
        .tags_clear ({m_tags_clear, s_tags_clear}),
        .rdat1      (rdat1),
        .rdat2      (rdat2),
        .rsel1      (rsel1),
        .rsel2      (rsel2),
        .busy       (busy),
        .issue      (issue)
    );

endmodule

`default_nettype wire

/* issue_stage_tb.sv */
/* Directed testbench for the issue stage, covering dispatch, tag wait, age order and freeze.
   Compiled from the file list with the RTL, it ends with a status line. */
`default_nettype none

module issue_stage_tb;

    logic                   CLK;
    logic                   nRST;
    issue_pkg::dispatch_t   dispatch;
    issue_pkg::wb_t         wb;
    logic                   freeze;
    issue_pkg::issue_t      issue;
    issue_pkg::row_status_t busy;

    logic [31:0]            seed;
    logic [31:0]            model_regs [32];

    issue_stage issue_stage_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .dispatch (dispatch),
        .wb       (wb),
        .freeze   (freeze),
        .issue    (issue),
        .busy     (busy)
    );

    always #5 CLK = ~CLK;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Expected packets follow the register model
    function automatic issue_pkg::issue_t scalar_packet(issue_pkg::fu_e fu, logic [4:0] rs1,
                                                        logic [4:0] rs2);
        issue_pkg::issue_t p;
        p       = '0;
        p.valid = 1'b1;
        p.fu    = fu;
        p.rdat1 = model_regs[rs1];
        p.rdat2 = model_regs[rs2];
        return p;
    endfunction

    function automatic issue_pkg::issue_t gemm_packet(logic [3:0] ms1, logic [3:0] ms2,
                                                      logic [3:0] ms3);
        issue_pkg::issue_t p;
        p       = '0;
        p.valid = 1'b1;
        p.fu    = issue_pkg::FU_GEMM;
        p.ms1   = ms1;
        p.ms2   = ms2;
        p.ms3   = ms3;
        return p;
    endfunction

    task automatic check_issue(issue_pkg::issue_t exp, string what);
        if (issue !== exp) begin
            $display("error at time %0t: %s, issue %h, expected %h", $time, what, issue, exp);
            $display("STATUS: FAIL");
            $fatal(1, "issue packet mismatch");
        end
    endtask

    task automatic check_busy(issue_pkg::row_status_t exp, string what);
        if (busy !== exp) begin
            $display("error at time %0t: %s, busy %b, expected %b", $time, what, busy, exp);
            $display("STATUS: FAIL");
            $fatal(1, "busy mismatch");
        end
    endtask

    // One writeback pulse that the register model follows
    task automatic send_wb(issue_pkg::fu_e done, logic rw_en, logic [4:0] rw, logic [31:0] data);
        wb         = '0;
        wb.rw_en   = rw_en;
        wb.rw      = rw;
        wb.wdata   = data;
        wb.done_fu = done;
        if (rw_en && rw != 5'd0) model_regs[rw] = data;
        @(negedge CLK);
        wb = '0;
    endtask

    task automatic dispatch_scalar(issue_pkg::fu_e fu, logic [4:0] rs1, logic [4:0] rs2,
                                   issue_pkg::fu_e t1, issue_pkg::fu_e t2);
        dispatch          = '0;
        dispatch.s_en     = 1'b1;
        dispatch.s_fu     = fu;
        dispatch.s_row.rs1 = rs1;
        dispatch.s_row.rs2 = rs2;
        dispatch.s_row.t1 = t1;
        dispatch.s_row.t2 = t2;
        @(negedge CLK);
        dispatch = '0;
    endtask

    task automatic dispatch_gemm(logic [3:0] ms1, logic [3:0] ms2, logic [3:0] ms3,
                                 issue_pkg::fu_e t1, issue_pkg::fu_e t2, issue_pkg::fu_e t3);
        dispatch           = '0;
        dispatch.g_en      = 1'b1;
        dispatch.g_row.ms1 = ms1;
        dispatch.g_row.ms2 = ms2;
        dispatch.g_row.ms3 = ms3;
        dispatch.g_row.t1  = t1;
        dispatch.g_row.t2  = t2;
        dispatch.g_row.t3  = t3;
        @(negedge CLK);
        dispatch = '0;
    endtask

    task automatic wait_packet(issue_pkg::fu_e fu, output int cycles);
        cycles = 0;
        while (!(issue.valid && issue.fu == fu)) begin
            if (cycles == 20) begin
                $display("timed out waiting for an issue packet from unit %s", fu.name());
                $display("STATUS: FAIL");
                $fatal(1, "issue timeout");
            end
            @(negedge CLK);
            cycles++;
        end
    endtask

    task automatic expect_quiet(int n);
        repeat (n) begin
            @(negedge CLK);
            check_issue('0, "no issue expected");
        end
    endtask

    task automatic reset_values();
        check_issue('0, "issue after reset");
        check_busy('0, "busy after reset");
    endtask

    task automatic alu_single_issue();
        int cycles;
        for (int r = 1; r < 8; r++) send_wb(issue_pkg::FU_NONE, 1'b1, 5'(r), next_rand());
        dispatch_scalar(issue_pkg::FU_ALU, 5'd3, 5'd5, issue_pkg::FU_NONE, issue_pkg::FU_NONE);
        wait_packet(issue_pkg::FU_ALU, cycles);
        if (cycles != 1) begin
            $display("error at time %0t: ALU packet after %0d cycles, expected 1", $time, cycles);
            $display("STATUS: FAIL");
            $fatal(1, "issue latency");
        end
        check_issue(scalar_packet(issue_pkg::FU_ALU, 5'd3, 5'd5), "ALU packet");
        check_busy(5'b00001, "ALU in execute");
        @(negedge CLK);
        check_issue('0, "ALU packet lasts one cycle");
        send_wb(issue_pkg::FU_ALU, 1'b0, 5'd0, 32'd0);
        check_busy('0, "ALU row freed");
    endtask

    task automatic ld_st_tag_wait();
        int cycles;
        dispatch_scalar(issue_pkg::FU_ALU, 5'd1, 5'd2, issue_pkg::FU_NONE, issue_pkg::FU_NONE);
        wait_packet(issue_pkg::FU_ALU, cycles);
        dispatch_scalar(issue_pkg::FU_LD_ST, 5'd6, 5'd7, issue_pkg::FU_ALU, issue_pkg::FU_NONE);
        expect_quiet(4);
        check_busy(5'b00011, "LD_ST waits behind ALU");
        // ALU result lands in the LD_ST source register
        send_wb(issue_pkg::FU_ALU, 1'b1, 5'd6, next_rand());
        check_busy(5'b00010, "ALU freed, LD_ST pending");
        // rs2 is written in the cycle LD_ST reads it, so its value comes over the bypass
        send_wb(issue_pkg::FU_NONE, 1'b1, 5'd7, next_rand());
        wait_packet(issue_pkg::FU_LD_ST, cycles);
        check_issue(scalar_packet(issue_pkg::FU_LD_ST, 5'd6, 5'd7), "LD_ST packet");
        send_wb(issue_pkg::FU_LD_ST, 1'b0, 5'd0, 32'd0);
        check_busy('0, "LD_ST row freed");
    endtask

    task automatic oldest_row_first();
        int cycles;
        dispatch_scalar(issue_pkg::FU_BRANCH, 5'd1, 5'd4, issue_pkg::FU_MLS, issue_pkg::FU_NONE);
        dispatch_scalar(issue_pkg::FU_ALU, 5'd2, 5'd3, issue_pkg::FU_MLS, issue_pkg::FU_NONE);
        expect_quiet(2);
        send_wb(issue_pkg::FU_MLS, 1'b0, 5'd0, 32'd0);
        wait_packet(issue_pkg::FU_BRANCH, cycles);
        check_issue(scalar_packet(issue_pkg::FU_BRANCH, 5'd1, 5'd4), "older BRANCH first");
        @(negedge CLK);
        check_issue(scalar_packet(issue_pkg::FU_ALU, 5'd2, 5'd3), "younger ALU next");
        send_wb(issue_pkg::FU_BRANCH, 1'b0, 5'd0, 32'd0);
        send_wb(issue_pkg::FU_ALU, 1'b0, 5'd0, 32'd0);
        check_busy('0, "rows freed after age test");
    endtask

    task automatic freeze_holds_issue();
        int                cycles;
        logic [31:0]       r;
        issue_pkg::issue_t held;
        r = next_rand();
        dispatch_scalar(issue_pkg::FU_ALU, 5'd4, 5'd5, issue_pkg::FU_NONE, issue_pkg::FU_NONE);
        wait_packet(issue_pkg::FU_ALU, cycles);
        held = scalar_packet(issue_pkg::FU_ALU, 5'd4, 5'd5);
        check_issue(held, "ALU packet before freeze");
        freeze = 1'b1;
        dispatch_gemm(r[3:0], r[7:4], r[11:8], issue_pkg::FU_NONE, issue_pkg::FU_NONE,
                      issue_pkg::FU_NONE);
        repeat (4) begin
            check_issue(held, "issue held under freeze");
            @(negedge CLK);
        end
        check_busy(5'b10001, "GEMM held back by freeze");
        freeze = 1'b0;
        wait_packet(issue_pkg::FU_GEMM, cycles);
        check_issue(gemm_packet(r[3:0], r[7:4], r[11:8]), "GEMM packet after freeze");
        send_wb(issue_pkg::FU_ALU, 1'b0, 5'd0, 32'd0);
        send_wb(issue_pkg::FU_GEMM, 1'b0, 5'd0, 32'd0);
        check_busy('0, "rows freed after freeze test");
    endtask

    task automatic gemm_three_producers();
        int             cycles;
        int             j;
        logic [31:0]    r;
        issue_pkg::fu_e tmp;
        issue_pkg::fu_e order [3];
        order = '{issue_pkg::FU_ALU, issue_pkg::FU_LD_ST, issue_pkg::FU_BRANCH};
        // Shuffle the completion order of the three producers
        for (int i = 2; i > 0; i--) begin
            j        = int'((next_rand() >> 16) % 32'(i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        r = next_rand();
        dispatch_gemm(r[3:0], r[7:4], r[11:8], issue_pkg::FU_ALU, issue_pkg::FU_LD_ST,
                      issue_pkg::FU_BRANCH);
        for (int i = 0; i < 3; i++) begin
            expect_quiet(2);
            send_wb(order[i], 1'b0, 5'd0, 32'd0);
        end
        wait_packet(issue_pkg::FU_GEMM, cycles);
        check_issue(gemm_packet(r[3:0], r[7:4], r[11:8]), "GEMM packet after three producers");
        send_wb(issue_pkg::FU_GEMM, 1'b0, 5'd0, 32'd0);
        check_busy('0, "GEMM row freed");
    endtask

    initial begin
        CLK      = 1'b0;
        nRST     = 1'b0;
        dispatch = '0;
        wb       = '0;
        freeze   = 1'b0;
        seed     = 32'h95e6;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        reset_values();
        alu_single_issue();
        ld_st_tag_wait();
        oldest_row_first();
        freeze_holds_issue();
        gemm_three_producers();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* issue_stage.f */
issue_pkg.sv
regfile.sv
fust_scalar.sv
fust_matrix.sv
issue_select.sv
issue_stage.sv
issue_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f issue_stage.f --top-module issue_stage_tb \
    -o issue_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/issue_stage_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

printf '%s\n' "$out" | grep -qx "STATUS: PASS" || exit 1
exit 0
